// ==== logic/backplane_pkg.sv ====
// backplane package
// bus word types, I/O page device table and SPI idle levels for the backplane

package backplane_pkg;

   //**************************************************************************
   //* bus types
   //**************************************************************************
   typedef logic [15:0] word_t;     // bus data word
   typedef logic [1:0]  sel_t;      // byte selects, bit 1 = high byte

   // one address word, two readings of it
   typedef union packed {
      logic [15:0] raw;             // byte address, I/O page decode
      struct packed {
         logic [14:0] index;        // word index into RAM
         logic        byte_sel;     // odd byte
      } word;
   } bus_addr_u;

   localparam int N_MASTERS_DMA = 2;   // rk and my disk DMA
   localparam int N_SD          = 4;   // rk, dw, rx, my share the card
   localparam int N_IO          = 9;   // device slots on the I/O page

   //**************************************************************************
   //* device table
   //**************************************************************************
   typedef enum logic [3:0] {
      uart_con,      // console serial
      uart_aux,      // second serial
      printer,       // parallel printer
      rk_disk,
      dw_disk,
      rx_disk,
      my_disk,
      graphics,
      user_rom       // 140000-157777 when fitted
   } io_dev_e;

   // base addresses, same order as io_dev_e
   localparam word_t IO_BASE [N_IO] = '{
      16'o177560, 16'o176500, 16'o177514,
      16'o177400, 16'o174000, 16'o177170,
      16'o172140, 16'o176640, 16'o140000
   };

   // low address bits ignored per slot, i.e. register window size
   localparam int IO_SPAN_BITS [N_IO] = '{3, 3, 2, 4, 5, 2, 2, 3, 13};

   // card lines with no controller attached
   localparam logic SD_IDLE_CS   = 1'b1;  // deselected
   localparam logic SD_IDLE_MOSI = 1'b1;
   localparam logic SD_IDLE_SCLK = 1'b0;

endpackage

// ==== logic/wb_bus_if.sv ====
// shared Wishbone bus of the backplane
// driven by the granted master, read back by decoder and merger
`timescale 1ns/1ns

interface wb_bus_if;

   backplane_pkg::bus_addr_u adr;    // address, byte or word view
   backplane_pkg::word_t     dat_w;  // write data from master
   logic                     cyc;    // cycle open
   logic                     we;     // 1 = write
   backplane_pkg::sel_t      sel;    // byte selects
   logic                     stb;    // strobe
   logic                     ack;    // merged device ack
   backplane_pkg::word_t     dat_r;  // merged read data

   // granted master side
   modport master (output adr, dat_w, cyc, we, sel, stb,
                   input  ack, dat_r);

   // decoder and read merger side
   modport target (input  adr, dat_w, cyc, we, sel, stb,
                   output ack, dat_r);

endinterface

// ==== logic/bus_master_arbiter.sv ====
// bus master arbiter
// picks cpu or one of the DMA disk controllers and puts it onto the shared bus
`timescale 1ns/1ns

module bus_master_arbiter (
   input  logic                                    wb_clk,
   input  logic                                    rst_i,
   // processor
   input  backplane_pkg::word_t                    cpu_adr_i,
   input  backplane_pkg::word_t                    cpu_dat_i,
   input  logic                                    cpu_cyc_i,
   input  logic                                    cpu_we_i,
   input  logic                                    cpu_stb_i,
   input  backplane_pkg::sel_t                     cpu_sel_i,
   output logic                                    cpu_ack_o,
   // DMA masters, req doubles as cyc
   input  logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_req_i,
   input  logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_we_i,
   input  logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_stb_i,
   input  backplane_pkg::word_t                    dma_adr_i [backplane_pkg::N_MASTERS_DMA],
   input  backplane_pkg::word_t                    dma_dat_i [backplane_pkg::N_MASTERS_DMA],
   output logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_gnt_o,
   output logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_ack_o,
   wb_bus_if.master                                bus
);

   logic [backplane_pkg::N_MASTERS_DMA-1:0] gnt_q;     // one-hot DMA grant
   logic [backplane_pkg::N_MASTERS_DMA-1:0] gnt_next;  // lowest requester wins
   logic                                    cpu_own;   // no DMA granted

   backplane_pkg::word_t mux_adr;
   backplane_pkg::word_t mux_dat;
   logic                 mux_cyc;
   logic                 mux_we;
   logic                 mux_stb;

   //**************************************************************************
   //* grant register
   //**************************************************************************
   assign gnt_next = dma_req_i & (~dma_req_i + 1'b1);  // isolate lowest set bit

   // switch only between bus cycles
   always_ff @(posedge wb_clk) begin
      if (rst_i)
         gnt_q <= '0;
      else if (!bus.cyc)
         gnt_q <= gnt_next;   // no request -> back to cpu
   end

   assign cpu_own   = ~|gnt_q;
   assign dma_gnt_o = gnt_q;

   //**************************************************************************
   //* master multiplexer
   //**************************************************************************
   always_comb begin : master_mux
      mux_adr = cpu_own ? cpu_adr_i : '0;
      mux_dat = cpu_own ? cpu_dat_i : '0;
      mux_cyc = cpu_own & cpu_cyc_i;
      mux_we  = cpu_own & cpu_we_i;
      mux_stb = cpu_own & cpu_stb_i;
      for (int i = 0; i < backplane_pkg::N_MASTERS_DMA; i++) begin
         if (gnt_q[i]) begin
            mux_adr = mux_adr | dma_adr_i[i];
            mux_dat = mux_dat | dma_dat_i[i];
            mux_cyc = mux_cyc | dma_req_i[i];   // request holds the cycle open
            mux_we  = mux_we  | dma_we_i[i];
            mux_stb = mux_stb | dma_stb_i[i];
         end
      end
   end

   assign bus.adr.raw = mux_adr;
   assign bus.dat_w   = mux_dat;
   assign bus.cyc     = mux_cyc;
   assign bus.we      = mux_we;
   assign bus.stb     = mux_stb;
   assign bus.sel     = cpu_own ? cpu_sel_i : 2'b11;   // DMA moves whole words

   // ack back to the owner only, cpu stalls under DMA
   assign cpu_ack_o = cpu_own & bus.ack;
   assign dma_ack_o = gnt_q & {backplane_pkg::N_MASTERS_DMA{bus.ack}};

   a_dma_gnt_onehot: assert property (@(posedge wb_clk) disable iff (rst_i)
      $onehot0(gnt_q));

endmodule

// ==== logic/io_page_decoder.sv ====
// I/O page and memory decoder
// one select per device slot plus the RAM strobe
`timescale 1ns/1ns

module io_page_decoder #(
   parameter bit HAS_USER_ROM = 1'b0   // ROM window at 140000
) (
   wb_bus_if.target                       bus,
   output logic [backplane_pkg::N_IO-1:0] io_stb_o,
   output logic                           ram_stb_o
);

   localparam backplane_pkg::io_dev_e ROM_SLOT = backplane_pkg::user_rom;

   // ROM pushes top of RAM down by 8K bytes
   localparam backplane_pkg::word_t RAM_TOP = HAS_USER_ROM ? 16'o137777 : 16'o157777;

   logic bus_act;   // valid access in progress

   assign bus_act = bus.stb & bus.cyc;

   //**************************************************************************
   //* device slots
   //**************************************************************************
   for (genvar i = 0; i < backplane_pkg::N_IO; i++) begin : g_slot
      localparam int SH = backplane_pkg::IO_SPAN_BITS[i];   // window bits
      logic hit;

      assign hit = (bus.adr.raw >> SH) == (backplane_pkg::IO_BASE[i] >> SH);

      if (i == int'(ROM_SLOT) && !HAS_USER_ROM) begin : g_no_rom
         assign io_stb_o[i] = 1'b0;   // slot empty
      end else begin : g_dev
         assign io_stb_o[i] = bus_act & hit;
      end
   end

   // RAM from 000000 up to its top
   assign ram_stb_o = bus_act & (bus.adr.raw <= RAM_TOP);

   // device windows must not overlap
   a_io_stb_onehot: assert final ($onehot0(io_stb_o));

endmodule

// ==== logic/read_merge.sv ====
// read side merger
// collects device acks and strobed read data onto the shared bus
`timescale 1ns/1ns

module read_merge (
   wb_bus_if.target                       bus,
   input  logic [backplane_pkg::N_IO-1:0] io_stb_i,
   input  logic                           ram_stb_i,
   input  logic                           sysram_stb_i,   // cpu board private RAM
   input  logic [backplane_pkg::N_IO-1:0] io_ack_i,
   input  backplane_pkg::word_t           io_dat_i [backplane_pkg::N_IO],
   input  logic                           ram_ack_i,
   input  backplane_pkg::word_t           ram_dat_i,
   output logic                           ram_stb_o
);

   backplane_pkg::word_t rd_mux;

   assign ram_stb_o = ram_stb_i | sysram_stb_i;   // system area also lives in RAM

   // any responder closes the cycle
   assign bus.ack = ram_ack_i | (|io_ack_i);

   //**************************************************************************
   //* read data OR-mux
   //**************************************************************************
   always_comb begin : data_or
      rd_mux = ram_stb_o ? ram_dat_i : '0;
      for (int i = 0; i < backplane_pkg::N_IO; i++) begin
         if (io_stb_i[i])
            rd_mux = rd_mux | io_dat_i[i];   // unselected sources give 0
      end
   end

   assign bus.dat_r = rd_mux;

endmodule

// ==== logic/sd_card_arbiter.sv ====
// SD card arbiter
// lends the one card to a disk controller and steers its SPI lines
`timescale 1ns/1ns

module sd_card_arbiter #(
   // idle {cs, mosi, sclk}
   parameter logic [2:0] SD_IDLE = {backplane_pkg::SD_IDLE_CS,
                                    backplane_pkg::SD_IDLE_MOSI,
                                    backplane_pkg::SD_IDLE_SCLK}
) (
   input  logic                           wb_clk,
   input  logic                           rst_i,
   input  logic [backplane_pkg::N_SD-1:0] sd_req_i,    // rk, dw, rx, my
   input  logic [backplane_pkg::N_SD-1:0] sd_cs_i,
   input  logic [backplane_pkg::N_SD-1:0] sd_mosi_i,
   input  logic [backplane_pkg::N_SD-1:0] sd_sclk_i,
   output logic [backplane_pkg::N_SD-1:0] sd_gnt_o,
   output logic                           sdcard_cs_o,
   output logic                           sdcard_mosi_o,
   output logic                           sdcard_sclk_o
);

   logic [backplane_pkg::N_SD-1:0] gnt_q;
   logic [backplane_pkg::N_SD-1:0] first_req;   // highest priority requester
   logic                           held;        // card in use

   assign first_req = sd_req_i & (~sd_req_i + 1'b1);
   assign held      = |gnt_q;

   //**************************************************************************
   //* grant
   //**************************************************************************
   always_ff @(posedge wb_clk) begin
      if (rst_i)
         gnt_q <= '0;
      else if (!held)
         gnt_q <= first_req;            // idle, take the next one
      else
         gnt_q <= gnt_q & sd_req_i;     // holder keeps it until req drops
   end

   assign sd_gnt_o = gnt_q;

   //**************************************************************************
   //* SPI steering
   //**************************************************************************
   assign sdcard_cs_o   = held ? |(gnt_q & sd_cs_i)   : SD_IDLE[2];
   assign sdcard_mosi_o = held ? |(gnt_q & sd_mosi_i) : SD_IDLE[1];
   assign sdcard_sclk_o = held ? |(gnt_q & sd_sclk_i) : SD_IDLE[0];

   a_sd_gnt_onehot: assert property (@(posedge wb_clk) disable iff (rst_i)
      $onehot0(gnt_q));

endmodule

// ==== logic/backplane.sv ====
// backplane top level
// master arbitration, address decode, read merge and SD card sharing
`timescale 1ns/1ns

module backplane #(
   parameter bit         HAS_USER_ROM = 1'b0,
   parameter logic [2:0] SD_IDLE      = {backplane_pkg::SD_IDLE_CS,
                                         backplane_pkg::SD_IDLE_MOSI,
                                         backplane_pkg::SD_IDLE_SCLK}
) (
   input  logic                                    wb_clk,
   input  logic                                    rst_i,
   // processor
   input  backplane_pkg::word_t                    cpu_adr_i,
   input  backplane_pkg::word_t                    cpu_dat_i,
   input  logic                                    cpu_cyc_i,
   input  logic                                    cpu_we_i,
   input  logic                                    cpu_stb_i,
   input  backplane_pkg::sel_t                     cpu_sel_i,
   output logic                                    cpu_ack_o,
   // DMA masters
   input  logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_req_i,
   input  logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_we_i,
   input  logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_stb_i,
   input  backplane_pkg::word_t                    dma_adr_i [backplane_pkg::N_MASTERS_DMA],
   input  backplane_pkg::word_t                    dma_dat_i [backplane_pkg::N_MASTERS_DMA],
   output logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_gnt_o,
   output logic [backplane_pkg::N_MASTERS_DMA-1:0] dma_ack_o,
   // shared bus towards devices
   output backplane_pkg::word_t                    bus_adr_o,
   output backplane_pkg::word_t                    bus_dat_o,
   output logic                                    bus_we_o,
   output backplane_pkg::sel_t                     bus_sel_o,
   output logic [backplane_pkg::N_IO-1:0]          io_stb_o,
   input  logic [backplane_pkg::N_IO-1:0]          io_ack_i,
   input  backplane_pkg::word_t                    io_dat_i [backplane_pkg::N_IO],
   // RAM
   output logic                                    ram_stb_o,
   input  logic                                    ram_ack_i,
   input  backplane_pkg::word_t                    ram_dat_i,
   output logic [14:0]                             ram_adr_o,
   input  logic                                    sysram_stb_i,
   output backplane_pkg::word_t                    rd_dat_o,   // to all masters
   // SD card
   input  logic [backplane_pkg::N_SD-1:0]          sd_req_i,
   input  logic [backplane_pkg::N_SD-1:0]          sd_cs_i,
   input  logic [backplane_pkg::N_SD-1:0]          sd_mosi_i,
   input  logic [backplane_pkg::N_SD-1:0]          sd_sclk_i,
   output logic [backplane_pkg::N_SD-1:0]          sd_gnt_o,
   output logic                                    sdcard_cs_o,
   output logic                                    sdcard_mosi_o,
   output logic                                    sdcard_sclk_o
);

   wb_bus_if bus_if ();

   logic dec_ram_stb;   // RAM hit before sysram is added

   bus_master_arbiter master_arb_i (
      .wb_clk, .rst_i,
      .cpu_adr_i, .cpu_dat_i, .cpu_cyc_i, .cpu_we_i, .cpu_stb_i, .cpu_sel_i, .cpu_ack_o,
      .dma_req_i, .dma_we_i, .dma_stb_i, .dma_adr_i, .dma_dat_i, .dma_gnt_o, .dma_ack_o,
      .bus (bus_if.master)
   );

   io_page_decoder #(.HAS_USER_ROM(HAS_USER_ROM)) decoder_i (
      .bus       (bus_if.target),
      .io_stb_o  (io_stb_o),
      .ram_stb_o (dec_ram_stb)
   );

   read_merge merge_i (
      .bus          (bus_if.target),
      .io_stb_i     (io_stb_o),
      .ram_stb_i    (dec_ram_stb),
      .sysram_stb_i (sysram_stb_i),
      .io_ack_i     (io_ack_i),
      .io_dat_i     (io_dat_i),
      .ram_ack_i    (ram_ack_i),
      .ram_dat_i    (ram_dat_i),
      .ram_stb_o    (ram_stb_o)
   );

   sd_card_arbiter #(.SD_IDLE(SD_IDLE)) sd_arb_i (
      .wb_clk, .rst_i,
      .sd_req_i, .sd_cs_i, .sd_mosi_i, .sd_sclk_i, .sd_gnt_o,
      .sdcard_cs_o, .sdcard_mosi_o, .sdcard_sclk_o
   );

   assign bus_adr_o = bus_if.adr.raw;
   assign bus_dat_o = bus_if.dat_w;
   assign bus_we_o  = bus_if.we;
   assign bus_sel_o = bus_if.sel;
   assign ram_adr_o = bus_if.adr.word.index;   // word address for RAM
   assign rd_dat_o  = bus_if.dat_r;

endmodule

// ==== tb/backplane_model.svh ====
// backplane reference model
// tracks both grant registers and predicts every bus output from the inputs
`ifndef BACKPLANE_MODEL_SVH
`define BACKPLANE_MODEL_SVH

// device windows as base address and ignored low bits per slot
localparam logic [15:0] DEV_BASE [9] = '{16'o177560, 16'o176500, 16'o177514,
                                         16'o177400, 16'o174000, 16'o177170,
                                         16'o172140, 16'o176640, 16'o140000};
localparam int DEV_SPAN [9] = '{3, 3, 2, 4, 5, 2, 2, 3, 13};

logic [1:0]           m_dma_gnt;   // predicted DMA grant
logic [3:0]           m_sd_gnt;    // predicted SD grant
backplane_pkg::word_t e_adr;
backplane_pkg::word_t e_dat;
backplane_pkg::word_t e_rd;
backplane_pkg::sel_t  e_sel;
logic [8:0]           e_io_stb;
logic                 e_we, e_cyc, e_stb, e_ram_stb, e_ack;
logic                 e_cs, e_mosi, e_sclk;

//**************************************************************************
//* combinational prediction
//**************************************************************************
task automatic model_outputs();
   int g;
   int h;
   int i;
   g = m_dma_gnt[1] ? 1 : 0;
   if (m_dma_gnt == 2'b00) begin   // cpu owns the bus
      e_adr = cpu_adr_i;
      e_dat = cpu_dat_i;
      e_we  = cpu_we_i;
      e_sel = cpu_sel_i;
      e_cyc = cpu_cyc_i;
      e_stb = cpu_stb_i;
   end else begin
      e_adr = dma_adr_i[g];
      e_dat = dma_dat_i[g];
      e_we  = dma_we_i[g];
      e_sel = 2'b11;              // whole words under DMA
      e_cyc = dma_req_i[g];       // request is the cycle
      e_stb = dma_stb_i[g];
   end
   e_io_stb  = '0;
   e_ram_stb = sysram_stb_i;
   if (e_cyc && e_stb) begin
      // window of 2**span bytes starting at the base
      for (i = 0; i < 9; i++)
         e_io_stb[i] = (e_adr >= DEV_BASE[i]) && (e_adr < DEV_BASE[i] + (1 << DEV_SPAN[i]));
      if (!HAS_ROM)
         e_io_stb[8] = 1'b0;      // user ROM slot empty
      e_ram_stb = sysram_stb_i | (e_adr <= (HAS_ROM ? 16'o137777 : 16'o157777));
   end
   e_rd = e_ram_stb ? ram_dat_i : '0;
   for (i = 0; i < 9; i++) begin
      if (e_io_stb[i])
         e_rd = e_rd | io_dat_i[i];
   end
   e_ack = ram_ack_i | (|io_ack_i);
   h = -1;
   for (i = 0; i < 4; i++) begin
      if (m_sd_gnt[i])
         h = i;                   // card holder
   end
   if (h < 0) begin
      e_cs   = 1'b1;              // card deselected when idle
      e_mosi = 1'b1;
      e_sclk = 1'b0;
   end else begin
      e_cs   = sd_cs_i[h];
      e_mosi = sd_mosi_i[h];
      e_sclk = sd_sclk_i[h];
   end
endtask

// one rising edge of both arbiters before new stimulus lands
task automatic model_clock();
   int i;
   model_outputs();                // pre-edge bus state
   if (!e_cyc)
      m_dma_gnt = dma_req_i[0] ? 2'b01 : (dma_req_i[1] ? 2'b10 : 2'b00);
   if (m_sd_gnt == '0) begin
      for (i = 3; i >= 0; i--) begin
         if (sd_req_i[i])
            m_sd_gnt = 4'b0001 << i;   // lowest index wins
      end
   end else if (!(|(m_sd_gnt & sd_req_i))) begin
      m_sd_gnt = '0;               // holder let go
   end
endtask

//**************************************************************************
//* compare tasks
//**************************************************************************
task automatic check_word(input string name, input backplane_pkg::word_t got,
                          input backplane_pkg::word_t exp);
   if (got !== exp)
      report_mismatch(name, got, exp);
endtask

task automatic check_grant(input string name,
                           input logic [backplane_pkg::N_MASTERS_DMA-1:0] got,
                           input logic [backplane_pkg::N_MASTERS_DMA-1:0] exp);
   if (got !== exp)
      report_mismatch(name, got, exp);
endtask

task automatic check_sd(input string name, input logic [backplane_pkg::N_SD-1:0] got,
                        input logic [backplane_pkg::N_SD-1:0] exp);
   if (got !== exp)
      report_mismatch(name, got, exp);
endtask

task automatic check_stb(input string name, input logic [backplane_pkg::N_IO-1:0] got,
                         input logic [backplane_pkg::N_IO-1:0] exp);
   if (got !== exp)
      report_mismatch(name, got, exp);
endtask

task automatic check_sel(input string name, input backplane_pkg::sel_t got,
                         input backplane_pkg::sel_t exp);
   if (got !== exp)
      report_mismatch(name, got, exp);
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp)
      report_mismatch(name, got, exp);
endtask

`endif

// ==== tb/backplane_tb.sv ====
// backplane testbench
// random masters, devices and SD clients checked against a cycle model
`timescale 1ns/1ns

module backplane_tb;

   localparam bit HAS_ROM     = 1'b1;
   localparam int N_CYCLES    = 2000;
   localparam int CLK_NS      = 20;
   localparam int WATCHDOG_NS = N_CYCLES * CLK_NS * 11 / 10;   // run length plus 10 %

   logic                 wb_clk;
   logic                 rst_i;
   backplane_pkg::word_t cpu_adr_i, cpu_dat_i;
   logic                 cpu_cyc_i, cpu_we_i, cpu_stb_i, cpu_ack_o;
   backplane_pkg::sel_t  cpu_sel_i;
   logic [1:0]           dma_req_i, dma_we_i, dma_stb_i, dma_gnt_o, dma_ack_o;
   backplane_pkg::word_t dma_adr_i [2];
   backplane_pkg::word_t dma_dat_i [2];
   backplane_pkg::word_t bus_adr_o, bus_dat_o, rd_dat_o, ram_dat_i;
   logic                 bus_we_o;
   backplane_pkg::sel_t  bus_sel_o;
   logic [8:0]           io_stb_o, io_ack_i;
   backplane_pkg::word_t io_dat_i [9];
   logic                 ram_stb_o, ram_ack_i, sysram_stb_i;
   logic [14:0]          ram_adr_o;
   logic [3:0]           sd_req_i, sd_cs_i, sd_mosi_i, sd_sclk_i, sd_gnt_o;
   logic                 sdcard_cs_o, sdcard_mosi_o, sdcard_sclk_o;
   integer               seed = 32'h50935ed5;

   `include "backplane_model.svh"

   backplane #(.HAS_USER_ROM(HAS_ROM)) backplane_i (.*);

   initial begin : clock_gen
      wb_clk = 1'b0;
      forever #(CLK_NS / 2) wb_clk = ~wb_clk;
   end

   //**************************************************************************
   //* error exit
   //**************************************************************************
   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("ERROR: run still going after %0d ns, stimulus loop is stuck", WATCHDOG_NS);
      abort_run();
   end

   //**************************************************************************
   //* stimulus
   //**************************************************************************
   // address near a device window, around top of RAM, or anywhere
   function automatic backplane_pkg::word_t pick_addr();
      logic [31:0] r;
      r = $random(seed);
      case (r[1:0])
         2'd0:    return DEV_BASE[r[5:2] % 9] + r[21:16];
         2'd1:    return 16'o137700 + r[23:16];   // crosses into ROM
         default: return r[31:16];
      endcase
   endfunction

   task automatic init_inputs();
      int i;
      {cpu_adr_i, cpu_dat_i, cpu_cyc_i, cpu_we_i, cpu_stb_i, cpu_sel_i} = '0;
      {dma_req_i, dma_we_i, dma_stb_i, io_ack_i, ram_ack_i, ram_dat_i} = '0;
      {sysram_stb_i, sd_req_i, sd_cs_i, sd_mosi_i, sd_sclk_i} = '0;
      for (i = 0; i < 2; i++) begin
         dma_adr_i[i] = '0;
         dma_dat_i[i] = '0;
      end
      for (i = 0; i < 9; i++)
         io_dat_i[i] = '0;
   endtask

   task automatic drive_random();
      logic [31:0] r;
      int i;
      r = $random(seed);
      cpu_adr_i    <= pick_addr();
      cpu_dat_i    <= r[15:0];
      cpu_cyc_i    <= r[16] | r[17];   // mostly open
      cpu_stb_i    <= r[18];
      cpu_we_i     <= r[19];
      cpu_sel_i    <= r[21:20];
      dma_req_i    <= r[23:22];
      dma_we_i     <= r[25:24];
      dma_stb_i    <= r[27:26];
      sysram_stb_i <= r[28] & r[29];   // rare
      ram_ack_i    <= r[30];
      r = $random(seed);
      ram_dat_i    <= r[15:0];
      io_ack_i     <= r[24:16];
      sd_req_i     <= r[28:25];
      r = $random(seed);
      sd_cs_i      <= r[3:0];
      sd_mosi_i    <= r[7:4];
      sd_sclk_i    <= r[11:8];
      for (i = 0; i < 2; i++) begin
         r = $random(seed);
         dma_adr_i[i] <= pick_addr();
         dma_dat_i[i] <= r[15:0];
      end
      for (i = 0; i < 9; i++) begin
         r = $random(seed);
         io_dat_i[i] <= r[15:0];
      end
   endtask

   task automatic check_outputs();
      check_grant("dma_gnt_o", dma_gnt_o, m_dma_gnt);
      check_sd("sd_gnt_o", sd_gnt_o, m_sd_gnt);
      check_word("bus_adr_o", bus_adr_o, e_adr);
      check_word("bus_dat_o", bus_dat_o, e_dat);
      check_word("ram_adr_o", {1'b0, ram_adr_o}, {1'b0, e_adr[15:1]});
      check_bit("bus_we_o", bus_we_o, e_we);
      check_sel("bus_sel_o", bus_sel_o, e_sel);
      check_stb("io_stb_o", io_stb_o, e_io_stb);
      check_bit("ram_stb_o", ram_stb_o, e_ram_stb);
      check_word("rd_dat_o", rd_dat_o, e_rd);
      check_bit("cpu_ack_o", cpu_ack_o, e_ack & (m_dma_gnt == 2'b00));
      check_grant("dma_ack_o", dma_ack_o, m_dma_gnt & {2{e_ack}});
      check_bit("sdcard_cs_o", sdcard_cs_o, e_cs);
      check_bit("sdcard_mosi_o", sdcard_mosi_o, e_mosi);
      check_bit("sdcard_sclk_o", sdcard_sclk_o, e_sclk);
   endtask

   //**************************************************************************
   //* main sequence
   //**************************************************************************
   initial begin : run
      int n;
      init_inputs();
      rst_i = 1'b1;
      repeat (3) @(posedge wb_clk);
      rst_i     <= 1'b0;
      m_dma_gnt = '0;                  // cpu owns the bus after reset
      m_sd_gnt  = '0;
      for (n = 0; n < N_CYCLES; n++) begin
         if (n > 0) begin
            @(posedge wb_clk);
            model_clock();             // sees inputs before this edge
         end
         drive_random();
         @(negedge wb_clk);            // outputs settled mid cycle
         model_outputs();
         check_outputs();
      end
      $display("All tests passed");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+tb
logic/backplane_pkg.sv
logic/wb_bus_if.sv
logic/bus_master_arbiter.sv
logic/io_page_decoder.sv
logic/read_merge.sv
logic/sd_card_arbiter.sv
logic/backplane.sv
tb/backplane_tb.sv

// ==== Bender.yml ====
package:
  name: backplane

sources:
  - logic/backplane_pkg.sv
  - logic/wb_bus_if.sv
  - logic/bus_master_arbiter.sv
  - logic/io_page_decoder.sv
  - logic/read_merge.sv
  - logic/sd_card_arbiter.sv
  - logic/backplane.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/backplane_tb.sv
